// File: design/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [processor_pkg::XLEN-1:0] operand_a,
    input  logic [processor_pkg::XLEN-1:0] operand_b,
    input  logic [4:0]                     aluop,
    input  logic [4:0]                     shamt,
    output logic [processor_pkg::XLEN-1:0] result,
    output logic                           not_equal,
    output logic                           less_than
);
    import processor_pkg::*;

    always_comb begin
        case (aluop)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_SLL: result = operand_a << shamt;
            ALU_SRA: result = $signed(operand_a) >>> shamt;  // Sign bit fills
            default: result = operand_a + operand_b;
        endcase
    end

    // Branch flags, signed compare
    assign not_equal = (operand_a != operand_b);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 stall_fd,
    input  logic                                 redirect,
    input  logic [processor_pkg::XLEN-1:0]       fd_pc,
    input  logic [processor_pkg::XLEN-1:0]       fd_ir,
    input  logic [processor_pkg::XLEN-1:0]       read_data_a,
    input  logic [processor_pkg::XLEN-1:0]       read_data_b,
    output logic [processor_pkg::REG_ADDR_W-1:0] read_reg_a,
    output logic [processor_pkg::REG_ADDR_W-1:0] read_reg_b,
    output logic [processor_pkg::XLEN-1:0]       dx_pc,
    output logic [processor_pkg::XLEN-1:0]       dx_a,
    output logic [processor_pkg::XLEN-1:0]       dx_b,
    output logic [processor_pkg::XLEN-1:0]       dx_imm,
    output logic [processor_pkg::REG_ADDR_W-1:0] dx_rs,
    output logic [processor_pkg::REG_ADDR_W-1:0] dx_rt,
    output logic [processor_pkg::REG_ADDR_W-1:0] dx_rd,
    output logic [4:0]                           dx_aluop,
    output logic [4:0]                           dx_shamt,
    output logic                                 dx_use_imm,
    output logic                                 dx_reg_write,
    output logic                                 dx_mem_write,
    output logic                                 dx_mem_read,
    output logic                                 dx_bne,
    output logic                                 dx_blt,
    output logic                                 dx_jump
);
    import processor_pkg::*;

    logic [4:0]            opcode;
    logic [REG_ADDR_W-1:0] rd, rs, rt;
    logic [XLEN-1:0]       imm_ext;
    logic                  is_alu, is_addi, is_sw, is_lw, is_bne, is_blt, is_j;
    logic                  is_branch, use_a, use_b, bubble;

    // ----------------------------------------------------------
    // Fields and control decode
    // ----------------------------------------------------------
    assign opcode    = fd_ir[OPCODE_MSB -: 5];
    assign rd        = fd_ir[RD_MSB -: REG_ADDR_W];
    assign rs        = fd_ir[RS_MSB -: REG_ADDR_W];
    assign rt        = fd_ir[RT_MSB -: REG_ADDR_W];
    assign is_alu    = (opcode == OP_ALU);
    assign is_addi   = (opcode == OP_ADDI);
    assign is_sw     = (opcode == OP_SW);
    assign is_lw     = (opcode == OP_LW);
    assign is_bne    = (opcode == OP_BNE);
    assign is_blt    = (opcode == OP_BLT);
    assign is_j      = (opcode == OP_J);
    assign is_branch = is_bne | is_blt;

    // Branches compare rd against rs
    assign read_reg_a = is_branch ? rd : rs;
    assign read_reg_b = is_sw ? rd : (is_branch ? rs : rt);  // Store data sits in rd
    assign use_a      = is_alu | is_addi | is_lw | is_sw | is_branch;
    assign use_b      = is_alu | is_sw | is_branch;

    // j carries a 27-bit absolute target
    assign imm_ext = is_j ? {{(XLEN-RD_MSB-1){1'b0}}, fd_ir[RD_MSB:0]}
                          : {{(XLEN-IMM_W){fd_ir[IMM_W-1]}}, fd_ir[IMM_W-1:0]};

    assign bubble = stall_fd | redirect;

    // DX control flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_use_imm   <= 1'b0;
            dx_reg_write <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_bne       <= 1'b0;
            dx_blt       <= 1'b0;
            dx_jump      <= 1'b0;
        end else begin
            dx_use_imm   <= !bubble && (is_addi | is_lw | is_sw);
            dx_reg_write <= !bubble && (is_alu | is_addi | is_lw) && (rd != '0);
            dx_mem_write <= !bubble && is_sw;
            dx_mem_read  <= !bubble && is_lw;
            dx_bne       <= !bubble && is_bne;
            dx_blt       <= !bubble && is_blt;
            dx_jump      <= !bubble && is_j;
        end
    end

    // DX payload
    always_ff @(posedge clock) begin
        dx_pc    <= fd_pc;
        dx_a     <= read_data_a;
        dx_b     <= read_data_b;
        dx_imm   <= imm_ext;
        dx_rs    <= use_a ? read_reg_a : '0;        // r0 never matches a producer
        dx_rt    <= use_b ? read_reg_b : '0;
        dx_rd    <= rd;
        dx_aluop <= is_alu ? fd_ir[ALUOP_MSB -: 5] : ALU_ADD;  // Address and addi add
        dx_shamt <= fd_ir[SHAMT_MSB -: 5];
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [processor_pkg::XLEN-1:0]       dx_pc,
    input  logic [processor_pkg::XLEN-1:0]       dx_a,
    input  logic [processor_pkg::XLEN-1:0]       dx_b,
    input  logic [processor_pkg::XLEN-1:0]       dx_imm,
    input  logic [processor_pkg::REG_ADDR_W-1:0] dx_rt,
    input  logic [processor_pkg::REG_ADDR_W-1:0] dx_rd,
    input  logic [4:0]                           dx_aluop,
    input  logic [4:0]                           dx_shamt,
    input  logic                                 dx_use_imm,
    input  logic                                 dx_reg_write,
    input  logic                                 dx_mem_write,
    input  logic                                 dx_mem_read,
    input  logic                                 dx_bne,
    input  logic                                 dx_blt,
    input  logic                                 dx_jump,
    input  processor_pkg::fwd_sel_t              fwd_a,
    input  processor_pkg::fwd_sel_t              fwd_b,
    input  logic [processor_pkg::XLEN-1:0]       xm_result_in,
    input  logic [processor_pkg::XLEN-1:0]       mw_result,
    output logic                                 redirect,
    output logic [processor_pkg::XLEN-1:0]       redirect_pc,
    output logic [processor_pkg::XLEN-1:0]       xm_result,
    output logic [processor_pkg::XLEN-1:0]       xm_store_data,
    output logic [processor_pkg::REG_ADDR_W-1:0] xm_rd,
    output logic [processor_pkg::REG_ADDR_W-1:0] xm_rs_store,
    output logic                                 xm_reg_write,
    output logic                                 xm_mem_write,
    output logic                                 xm_mem_read
);
    import processor_pkg::*;

    logic [XLEN-1:0] op_a, op_b, alu_result;
    logic            not_equal, less_than;

    // Operand bypass muxes
    always_comb begin
        case (fwd_a)
            FWD_XM:  op_a = xm_result_in;
            FWD_MW:  op_a = mw_result;
            default: op_a = dx_a;
        endcase
        case (fwd_b)
            FWD_XM:  op_b = xm_result_in;
            FWD_MW:  op_b = mw_result;
            default: op_b = dx_b;
        endcase
    end

    alu u_alu (
        .operand_a (op_a),
        .operand_b (dx_use_imm ? dx_imm : op_b),   // Immediate for addi, lw, sw
        .aluop     (dx_aluop),
        .shamt     (dx_shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Resolution in execute, fall-through already fetched
    assign redirect    = dx_jump | (dx_bne & not_equal) | (dx_blt & less_than);
    assign redirect_pc = dx_jump ? dx_imm : dx_pc + 1 + dx_imm;

    // ----------------------------------------------------------
    // XM latch
    // ----------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_reg_write <= 1'b0;
            xm_mem_write <= 1'b0;
            xm_mem_read  <= 1'b0;
            xm_rs_store  <= '0;
        end else begin
            xm_reg_write <= dx_reg_write;
            xm_mem_write <= dx_mem_write;
            xm_mem_read  <= dx_mem_read;
            xm_rs_store  <= dx_mem_write ? dx_rt : '0;  // Store data register
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= alu_result;                // Memory address for lw and sw
        xm_store_data <= op_b;
        xm_rd         <= dx_rd;
    end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           stall_fd,      // Load-use hold
    input  logic                           redirect,      // Taken branch or j in execute
    input  logic [processor_pkg::XLEN-1:0] redirect_pc,
    input  logic [processor_pkg::XLEN-1:0] q_imem,
    output logic [processor_pkg::XLEN-1:0] address_imem,
    output logic [processor_pkg::XLEN-1:0] fd_pc,
    output logic [processor_pkg::XLEN-1:0] fd_ir
);
    import processor_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    assign address_imem = pc;
    assign pc_next      = redirect ? redirect_pc : pc + 1;  // Static not-taken

    // PC and FD instruction
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            fd_ir <= '0;                            // Zero word decodes as a bubble
        end else if (redirect) begin
            pc    <= pc_next;
            fd_ir <= '0;                            // Squash wrong-path fetch
        end else if (!stall_fd) begin
            pc    <= pc_next;
            fd_ir <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall_fd) begin
            fd_pc <= pc;                            // Base for branch target
        end
    end

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  logic [processor_pkg::XLEN-1:0]       fd_ir,
    input  logic [processor_pkg::REG_ADDR_W-1:0] dx_rs,
    input  logic [processor_pkg::REG_ADDR_W-1:0] dx_rt,
    input  logic [processor_pkg::REG_ADDR_W-1:0] dx_rd,
    input  logic                                 dx_mem_read,
    input  logic [processor_pkg::REG_ADDR_W-1:0] xm_rd,
    input  logic                                 xm_reg_write,
    input  logic [processor_pkg::REG_ADDR_W-1:0] xm_rs_store,  // Zero unless XM is sw
    input  logic [processor_pkg::REG_ADDR_W-1:0] mw_rd,
    input  logic                                 mw_reg_write,
    output processor_pkg::fwd_sel_t              fwd_a,
    output processor_pkg::fwd_sel_t              fwd_b,
    output logic                                 fwd_store,
    output logic                                 stall_fd
);
    import processor_pkg::*;

    logic [4:0]            fd_op;
    logic [REG_ADDR_W-1:0] fd_src_a, fd_src_b;
    logic                  fd_branch, fd_use_a, fd_use_b;

    // Youngest nonzero producer wins
    function automatic fwd_sel_t pick(input logic [REG_ADDR_W-1:0] src);
        fwd_sel_t sel;
        sel = FWD_RF;
        if (src != '0 && mw_reg_write && mw_rd == src) begin
            sel = FWD_MW;
        end
        if (src != '0 && xm_reg_write && xm_rd == src) begin
            sel = FWD_XM;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick(dx_rs);
        fwd_b = pick(dx_rt);
    end

    // MW result patches sw data already latched in XM
    assign fwd_store = mw_reg_write && (mw_rd != '0) && (mw_rd == xm_rs_store);

    // ----------------------------------------------------------
    // Load-use check against the instruction in FD
    // ----------------------------------------------------------
    assign fd_op     = fd_ir[OPCODE_MSB -: 5];
    assign fd_branch = (fd_op == OP_BNE) || (fd_op == OP_BLT);
    assign fd_src_a  = fd_branch ? fd_ir[RD_MSB -: REG_ADDR_W] : fd_ir[RS_MSB -: REG_ADDR_W];
    assign fd_src_b  = fd_branch ? fd_ir[RS_MSB -: REG_ADDR_W] : fd_ir[RT_MSB -: REG_ADDR_W];
    assign fd_use_a  = (fd_op == OP_ALU) || (fd_op == OP_ADDI) || (fd_op == OP_LW)
                    || (fd_op == OP_SW) || fd_branch;
    assign fd_use_b  = (fd_op == OP_ALU) || fd_branch;  // sw data rides fwd_store

    assign stall_fd = dx_mem_read && (dx_rd != '0)
                   && ((fd_use_a && fd_src_a == dx_rd) || (fd_use_b && fd_src_b == dx_rd));

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [processor_pkg::XLEN-1:0]       xm_result,
    input  logic [processor_pkg::XLEN-1:0]       xm_store_data,
    input  logic [processor_pkg::REG_ADDR_W-1:0] xm_rd,
    input  logic                                 xm_reg_write,
    input  logic                                 xm_mem_write,
    input  logic                                 xm_mem_read,
    input  logic                                 fwd_store,
    input  logic [processor_pkg::XLEN-1:0]       q_dmem,
    output logic [processor_pkg::XLEN-1:0]       address_dmem,
    output logic [processor_pkg::XLEN-1:0]       data,
    output logic                                 wren,
    output logic                                 reg_we,
    output logic [processor_pkg::REG_ADDR_W-1:0] reg_waddr,
    output logic [processor_pkg::XLEN-1:0]       reg_wdata,    // Also the MW bypass value
    output logic [processor_pkg::REG_ADDR_W-1:0] mw_rd
);
    import processor_pkg::*;

    logic            mw_mem_read;
    logic [XLEN-1:0] mw_alu, mw_load;

    // Data memory drive
    assign address_dmem = xm_result;
    assign data         = fwd_store ? reg_wdata : xm_store_data;
    assign wren         = xm_mem_write;

    // MW latch
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            reg_we      <= 1'b0;
            mw_mem_read <= 1'b0;
        end else begin
            reg_we      <= xm_reg_write;
            mw_mem_read <= xm_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        mw_alu  <= xm_result;
        mw_load <= q_dmem;                          // Read data valid within the cycle
        mw_rd   <= xm_rd;
    end

    assign reg_waddr = mw_rd;
    assign reg_wdata = mw_mem_read ? mw_load : mw_alu;

endmodule

// File: design/processor_pkg.sv
package processor_pkg;

    // Datapath sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 17;                 // I-type immediate
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ----------------------------------------------------------
    // Opcodes in bits 31:27
    // ----------------------------------------------------------
    localparam logic [4:0] OP_ALU  = 5'b00000;      // R-type, op in aluop field
    localparam logic [4:0] OP_J    = 5'b00001;
    localparam logic [4:0] OP_BNE  = 5'b00010;
    localparam logic [4:0] OP_ADDI = 5'b00101;
    localparam logic [4:0] OP_BLT  = 5'b00110;
    localparam logic [4:0] OP_SW   = 5'b00111;
    localparam logic [4:0] OP_LW   = 5'b01000;

    // R-type aluop codes
    localparam logic [4:0] ALU_ADD = 5'b00000;
    localparam logic [4:0] ALU_SUB = 5'b00001;
    localparam logic [4:0] ALU_AND = 5'b00010;
    localparam logic [4:0] ALU_OR  = 5'b00011;
    localparam logic [4:0] ALU_SLL = 5'b00100;
    localparam logic [4:0] ALU_SRA = 5'b00101;

    // Top bit of each instruction field
    localparam int OPCODE_MSB = 31;
    localparam int RD_MSB     = 26;                 // Also top of the j target
    localparam int RS_MSB     = 21;
    localparam int RT_MSB     = 16;
    localparam int SHAMT_MSB  = 11;
    localparam int ALUOP_MSB  = 6;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,                              // Value read in decode
        FWD_XM = 2'd1,                              // ALU result one ahead
        FWD_MW = 2'd2                               // Write-back value two ahead
    } fwd_sel_t;

endpackage

// File: design/processor_top.sv
`timescale 1ns/1ns

module processor_top (
    input  logic                           clock,
    input  logic                           rst_n,
    output logic [processor_pkg::XLEN-1:0] address_imem,
    input  logic [processor_pkg::XLEN-1:0] q_imem,
    output logic [processor_pkg::XLEN-1:0] address_dmem,
    output logic [processor_pkg::XLEN-1:0] data,
    output logic                           wren,
    input  logic [processor_pkg::XLEN-1:0] q_dmem
);
    import processor_pkg::*;

    // FD and hazard control
    logic [XLEN-1:0]       fd_pc, fd_ir, redirect_pc;
    logic                  stall_fd, redirect, fwd_store;
    fwd_sel_t              fwd_a, fwd_b;

    // Register file ports
    logic [REG_ADDR_W-1:0] read_reg_a, read_reg_b, reg_waddr;
    logic [XLEN-1:0]       read_data_a, read_data_b, reg_wdata;
    logic                  reg_we;

    // DX latch
    logic [XLEN-1:0]       dx_pc, dx_a, dx_b, dx_imm;
    logic [REG_ADDR_W-1:0] dx_rs, dx_rt, dx_rd;
    logic [4:0]            dx_aluop, dx_shamt;
    logic                  dx_use_imm, dx_reg_write, dx_mem_write, dx_mem_read;
    logic                  dx_bne, dx_blt, dx_jump;

    // XM and MW latches
    logic [XLEN-1:0]       xm_result, xm_store_data;
    logic [REG_ADDR_W-1:0] xm_rd, xm_rs_store, mw_rd;
    logic                  xm_reg_write, xm_mem_write, xm_mem_read;

    // ----------------------------------------------------------
    // Pipeline stages, port names match the nets above
    // ----------------------------------------------------------
    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    register_file u_regfile (.*);

    hazard_unit u_hazard (
        .mw_reg_write (reg_we),                     // MW write flag is the RF enable
        .*
    );

    execute_stage u_execute (
        .xm_result_in (xm_result),
        .mw_result    (reg_wdata),
        .*
    );

    mem_wb_stage u_mem_wb (.*);

endmodule

// File: design/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [processor_pkg::REG_ADDR_W-1:0] read_reg_a,
    input  logic [processor_pkg::REG_ADDR_W-1:0] read_reg_b,
    output logic [processor_pkg::XLEN-1:0]       read_data_a,
    output logic [processor_pkg::XLEN-1:0]       read_data_b,
    input  logic                                 reg_we,
    input  logic [processor_pkg::REG_ADDR_W-1:0] reg_waddr,
    input  logic [processor_pkg::XLEN-1:0]       reg_wdata
);
    import processor_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && (reg_waddr != '0)) begin
            regs[reg_waddr] <= reg_wdata;           // r0 stays zero
        end
    end

    // Write-first so decode sees the value retiring this cycle
    assign read_data_a = (read_reg_a == '0) ? '0 :
                         (reg_we && reg_waddr == read_reg_a) ? reg_wdata : regs[read_reg_a];
    assign read_data_b = (read_reg_b == '0) ? '0 :
                         (reg_we && reg_waddr == read_reg_b) ? reg_wdata : regs[read_reg_b];

endmodule

// File: processor.f
design/processor_pkg.sv
design/alu.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/processor_top.sv
verification/tb_processor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_processor \
    -f processor.f -o tb_processor \
    && ./obj_dir/tb_processor > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/processor_stimulus.txt
// Hex words; @ lines give word indexes. FFFFFFFF closes each section
// @00 program, @40 initial data as address value, @60 expected stores as address data
@00
28400019 2881FFFA 00C22000 38C00020   // r1=25, r2=-6, add, sw 0x20
01022004 39000021 01422008 39400022   // sub, and
0182200C 39800023 01C20210 39C00024   // or, sll by 4
02040094 3A000025                     // sra by 1
2A400007 02929000 02D49004 3A800030   // r9=7, add and sub chains, sw two behind
3AC00031 2B160100 3B000032            // sw r11, addi r12, sw from XM
43400010 039A1000 3B800040            // lw then dependent add
43C00011 3BC00041                     // lw then sw of the loaded word
2C00005A 10440001 3C000050            // marker, taken bne skips 0x50
30440001 3C000051                     // not-taken blt keeps 0x51
30820001 3C000052                     // taken blt skips 0x52
08000023 3C000053 38400054 08000024   // j over 0x53, store r1, j to self
FFFFFFFF
@40
00000010 00001234
00000011 00ABCDEF
FFFFFFFF
@60
00000020 00000013 00000021 0000001F
00000022 00000018 00000023 FFFFFFFB
00000024 00000190 00000025 FFFFFFFD
00000030 0000000E 00000031 00000007
00000032 00000107
00000040 0000124D 00000041 00ABCDEF
00000051 0000005A 00000054 00000019
FFFFFFFF

// File: verification/tb_processor.sv
`timescale 1ns/1ns

module tb_processor;
    import processor_pkg::*;

    localparam int STIM_WORDS = 256;
    localparam int PROG_MAX   = 'h40;               // Program section ends here
    localparam int DATA_BASE  = 'h40;               // Initial data as address/value pairs
    localparam int EXP_BASE   = 'h60;               // Expected stores as address/data pairs
    localparam logic [XLEN-1:0] HALT = 32'hFFFF_FFFF;

    logic            clock, rst_n, wren;
    logic [XLEN-1:0] q_imem, q_dmem, address_imem, address_dmem, data;

    logic [XLEN-1:0] stim [STIM_WORDS];             // Raw image of the stimulus file
    logic [XLEN-1:0] dmem [256];
    int              prog_len, exp_count, exp_next, limit, cycles;
    int              test_errors, errors, passed, failed;
    bit              timed_out;
    string           test_names [1:5] = '{"reset state", "ALU operations",
                                          "XM and MW forwarding", "load-use stall",
                                          "branches and jump"};

    processor_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic finish_test(input int id);
        if (test_errors == 0) begin
            $display("Test %0d, %s: passed", id, test_names[id]);
            passed++;
        end else begin
            $display("Test %0d, %s: failed with %0d errors", id, test_names[id], test_errors);
            failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic load_stimulus();
        int i;
        $readmemh("verification/processor_stimulus.txt", stim);
        prog_len = 0;
        while (prog_len < PROG_MAX && stim[prog_len] != HALT) begin
            prog_len++;
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = 32'hD000_0000 | 32'(i);       // Untouched words carry their address
        end
        i = DATA_BASE;
        while (i < EXP_BASE && stim[i] != HALT) begin
            dmem[stim[i][7:0]] = stim[i+1];
            i += 2;
        end
        exp_count = 0;
        while (EXP_BASE + 2*exp_count < STIM_WORDS - 1
               && stim[EXP_BASE + 2*exp_count] != HALT) begin
            exp_count++;
        end
        limit = 4*prog_len + 50;                    // Generous bound per fetched word
    endtask

    task automatic check_reset_state();
        assert (wren == 1'b0 && address_imem == RESET_PC) else begin
            $display("ERROR wren/address_imem: got %h/%h, expected 0/%h",
                     wren, address_imem, RESET_PC);
            test_errors++;
        end
    endtask

    task automatic check_store();
        logic [XLEN-1:0] exp_addr, exp_data;
        assert (exp_next < exp_count) else begin
            $display("A store to address %h arrived after the last expected store", address_dmem);
            test_errors++;
        end
        if (exp_next < exp_count) begin
            exp_addr = stim[EXP_BASE + 2*exp_next];
            exp_data = stim[EXP_BASE + 2*exp_next + 1];
            assert (address_dmem == exp_addr) else begin
                $display("ERROR address_dmem: got %h, expected %h", address_dmem, exp_addr);
                test_errors++;
            end
            assert (data == exp_data) else begin
                $display("ERROR data: got %h, expected %h at %h", data, exp_data, exp_addr);
                test_errors++;
            end
            exp_next++;
            // Each test stores into its own block of sixteen words
            if (exp_next == exp_count || stim[EXP_BASE + 2*exp_next][7:4] != exp_addr[7:4]) begin
                finish_test(int'(exp_addr[7:4]));
            end
        end
    endtask

    // ----------------------------------------------------------
    // Memory models
    // ----------------------------------------------------------
    always @(negedge clock) begin
        q_imem <= (address_imem < 32'(prog_len)) ? stim[address_imem[7:0]] : '0;  // Nop past end
        q_dmem <= dmem[address_dmem[7:0]];
    end

    always @(posedge clock) begin
        if (rst_n && wren) begin
            check_store();
            dmem[address_dmem[7:0]] = data;         // Write lands on the rising edge
        end
    end

    initial begin
        int k;
        rst_n       = 1'b0;
        q_imem      = '0;
        q_dmem      = '0;
        exp_next    = 0;
        test_errors = 0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        cycles      = 0;
        timed_out   = 1'b0;
        load_stimulus();
        repeat (4) begin
            @(negedge clock);
            check_reset_state();
        end
        rst_n = 1'b1;                               // Released between rising edges
        check_reset_state();
        finish_test(1);

        while (exp_next < exp_count && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (exp_next < exp_count) begin
            timed_out = 1'b1;
            $display("Timeout after %0d cycles with %0d expected stores missing",
                     cycles, exp_count - exp_next);
            for (k = exp_next; k < exp_count; k++) begin
                $display("No store of %h to address %h arrived",
                         stim[EXP_BASE + 2*k + 1], stim[EXP_BASE + 2*k]);
            end
        end else begin
            repeat (4) @(negedge clock);            // Stray stores after the last one
        end
        errors += test_errors;
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
